//--- hw/periph_pkg.sv
/*
 * Peripheral wrapper package
 * Bus types, access-size codes, slot numbers and register offsets
 */
`default_nettype none

package periph_pkg;

    // Widths carried on the core bus and the slot buses
    typedef logic [10:0] bus_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  pins_t;
    typedef logic [3:0]  slot_t;
    typedef logic [5:0]  user_off_t;
    typedef logic [3:0]  simple_off_t;

    // Top bit picks the simple class, low four bits the slot
    typedef logic [4:0]  func_sel_t;

    // Request size code, shared by read and write
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_t;

    localparam int NUM_SLOTS = 16;

    // Populated slots
    localparam slot_t SLOT_GPIO     = 4'd1;
    localparam slot_t SLOT_SCRATCH0 = 4'd4;
    localparam slot_t SLOT_SCRATCH1 = 4'd5;
    localparam slot_t SIMPLE_BYTE0  = 4'd0;
    localparam slot_t SIMPLE_BYTE1  = 4'd1;

    // GPIO registers, function selects sit at 0x20 + 4 * pin
    localparam user_off_t GPIO_OFF_OUT = 6'h00;
    localparam user_off_t GPIO_OFF_IN  = 6'h04;
    localparam user_off_t GPIO_OFF_SEL = 6'h20;

    // Scratch registers
    localparam user_off_t SCR_OFF_DATA = 6'h00;
    localparam user_off_t SCR_OFF_IRQ  = 6'h04;

endpackage

`default_nettype wire

//--- hw/periph_bus_if.sv
/*
 * Slot buses between the address decode and the peripherals
 * Full interface with handshake, byte interface without
 */
`timescale 1ns/1ps
`default_nettype none

// Full-interface slot, 64-byte window with size codes and ready
interface periph_bus_if;
    periph_pkg::user_off_t    address;
    periph_pkg::word_t        wdata;
    periph_pkg::access_size_t write_n;
    periph_pkg::access_size_t read_n;
    periph_pkg::word_t        rdata;
    logic                     ready;

    modport decoder (
        output address,
        output wdata,
        output write_n,
        output read_n,
        input  rdata,
        input  ready
    );

    modport periph (
        input  address,
        input  wdata,
        input  write_n,
        input  read_n,
        output rdata,
        output ready
    );
endinterface

// Byte-interface slot, reads are combinational and always ready
interface byte_bus_if;
    periph_pkg::simple_off_t address;
    logic                    write;
    periph_pkg::byte_t       wdata;
    periph_pkg::byte_t       rdata;

    modport decoder (
        output address,
        output write,
        output wdata,
        input  rdata
    );

    modport periph (
        input  address,
        input  write,
        input  wdata,
        output rdata
    );
endinterface

`default_nettype wire

//--- hw/periph_addr_decode.sv
/*
 * Address decode for sixteen full slots and sixteen byte slots
 * Gates requests per slot and muxes the selected slot's response
 */
`timescale 1ns/1ps
`default_nettype none

module periph_addr_decode (
    input  periph_pkg::bus_addr_t    i_addr,
    input  periph_pkg::word_t        i_data,
    input  periph_pkg::access_size_t i_write_n,
    input  periph_pkg::access_size_t i_read_n,
    input  logic                     i_read_block,
    periph_bus_if.decoder            o_user [periph_pkg::NUM_SLOTS],
    byte_bus_if.decoder              o_simple [periph_pkg::NUM_SLOTS],
    output periph_pkg::word_t        o_rdata,
    output logic                     o_rready
);

    logic                     is_simple;
    periph_pkg::slot_t        user_slot;
    periph_pkg::slot_t        simple_slot;
    periph_pkg::access_size_t read_n_gated;
    logic                     write_req;

    // Response collected into plain arrays so it can be indexed by the address
    periph_pkg::word_t user_rdata [periph_pkg::NUM_SLOTS];
    logic              user_ready [periph_pkg::NUM_SLOTS];
    periph_pkg::byte_t simple_rdata [periph_pkg::NUM_SLOTS];

    assign is_simple   = i_addr[10];
    assign user_slot   = i_addr[9:6];
    assign simple_slot = i_addr[7:4];
    assign write_req   = i_write_n != periph_pkg::SIZE_NONE;

    // No new read reaches a slot while the returned word is being presented
    assign read_n_gated = i_read_block ? periph_pkg::SIZE_NONE : i_read_n;

    for (genvar g = 0; g < periph_pkg::NUM_SLOTS; g++) begin : g_slot
        logic user_hit;
        logic simple_hit;

        assign user_hit   = !is_simple && (user_slot == periph_pkg::slot_t'(g));
        assign simple_hit = is_simple && (simple_slot == periph_pkg::slot_t'(g));

        assign o_user[g].address = i_addr[5:0];
        assign o_user[g].wdata   = i_data;
        assign o_user[g].write_n = user_hit ? i_write_n : periph_pkg::SIZE_NONE;
        assign o_user[g].read_n  = user_hit ? read_n_gated : periph_pkg::SIZE_NONE;

        assign o_simple[g].address = i_addr[3:0];
        assign o_simple[g].write   = simple_hit && write_req;
        assign o_simple[g].wdata   = i_data[7:0];

        assign user_rdata[g]   = o_user[g].rdata;
        assign user_ready[g]   = o_user[g].ready;
        assign simple_rdata[g] = o_simple[g].rdata;
    end

    // Byte slots are always ready, their data is zero-extended
    always_comb begin
        if (is_simple) begin
            o_rdata  = {24'h0, simple_rdata[simple_slot]};
            o_rready = 1'b1;
        end else begin
            o_rdata  = user_rdata[user_slot];
            o_rready = user_ready[user_slot];
        end
    end

endmodule

`default_nettype wire

//--- hw/periph_read_return.sv
/*
 * Read return register toward the core
 * Captures read data once and holds it until the core reports completion
 */
`timescale 1ns/1ps
`default_nettype none

module periph_read_return (
    input  logic                     clk,
    input  logic                     rst_n,
    input  periph_pkg::access_size_t i_read_n,
    input  periph_pkg::access_size_t i_write_n,
    input  periph_pkg::word_t        i_rdata,
    input  logic                     i_rready,
    input  logic                     i_data_read_complete,
    output logic                     o_read_block,
    output periph_pkg::word_t        o_data,
    output logic                     o_data_ready
);

    logic              read_req;
    logic              capture;
    logic              hold_q;
    logic              ready_q;
    periph_pkg::word_t data_q;

    assign read_req = i_read_n != periph_pkg::SIZE_NONE;

    // Only one capture per held value, a pending read waits for completion
    assign capture = read_req && i_rready && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rdata;
        end
    end

    assign o_data       = data_q;
    assign o_read_block = ready_q;

    // Writes complete in the cycle they are presented
    assign o_data_ready = ready_q || (i_write_n != periph_pkg::SIZE_NONE);

endmodule

`default_nettype wire

//--- hw/gpio_ctrl.sv
/*
 * GPIO block: output register, input readback and per-pin function select
 * Each output pin is taken from the pin byte of its selected slot
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    periph_bus_if.periph      i_bus,
    input  periph_pkg::pins_t i_ui_in,
    input  periph_pkg::pins_t i_user_pins [periph_pkg::NUM_SLOTS],
    input  periph_pkg::pins_t i_simple_pins [periph_pkg::NUM_SLOTS],
    output periph_pkg::pins_t o_uo_out
);

    // Pin number bits inside the select window
    localparam periph_pkg::user_off_t SEL_PIN_BITS = 6'h1C;

    localparam periph_pkg::func_sel_t SEL_RESET = {1'b0, periph_pkg::SLOT_GPIO};

    periph_pkg::pins_t      out_q;
    periph_pkg::func_sel_t  sel_q [8];
    periph_pkg::pins_t      user_src [periph_pkg::NUM_SLOTS];
    periph_pkg::word_t      rdata;
    logic                   write_en;
    logic                   sel_hit;
    logic [2:0]             sel_pin;

    assign write_en = i_bus.write_n != periph_pkg::SIZE_NONE;
    assign sel_hit  = (i_bus.address & ~SEL_PIN_BITS) == periph_pkg::GPIO_OFF_SEL;
    assign sel_pin  = i_bus.address[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (write_en && i_bus.address == periph_pkg::GPIO_OFF_OUT) begin
            out_q <= i_bus.wdata[7:0];
        end
    end

    for (genvar i = 0; i < 8; i++) begin : g_pin
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                sel_q[i] <= SEL_RESET;
            end else if (write_en && sel_hit && sel_pin == 3'(i)) begin
                sel_q[i] <= i_bus.wdata[4:0];
            end
        end

        // Top select bit chooses the byte-slot class
        assign o_uo_out[i] = sel_q[i][4] ? i_simple_pins[sel_q[i][3:0]][i]
                                         : user_src[sel_q[i][3:0]][i];
    end

    // The GPIO slot's own pin byte is its output register
    for (genvar g = 0; g < periph_pkg::NUM_SLOTS; g++) begin : g_src
        assign user_src[g] = (g == int'(periph_pkg::SLOT_GPIO)) ? out_q : i_user_pins[g];
    end

    always_comb begin
        rdata = '0;
        if (i_bus.address == periph_pkg::GPIO_OFF_OUT) begin
            rdata = {24'h0, out_q};
        end else if (i_bus.address == periph_pkg::GPIO_OFF_IN) begin
            rdata = {24'h0, i_ui_in};
        end else if (sel_hit) begin
            rdata = {27'h0, sel_q[sel_pin]};
        end
    end

    assign i_bus.rdata = rdata;
    assign i_bus.ready = 1'b1;

endmodule

`default_nettype wire

//--- hw/scratch_peri.sv
/*
 * Scratch register on a full-interface slot
 * Size-aware writes, data write raises an interrupt, registered reads
 */
`timescale 1ns/1ps
`default_nettype none

module scratch_peri (
    input  logic              clk,
    input  logic              rst_n,
    periph_bus_if.periph      i_bus,
    output periph_pkg::pins_t o_pins,
    output logic              o_irq
);

    periph_pkg::word_t data_q;
    periph_pkg::word_t rdata_q;
    logic              irq_q;
    logic              ready_q;
    logic              write_en;
    logic              read_en;

    assign write_en = i_bus.write_n != periph_pkg::SIZE_NONE;
    assign read_en  = i_bus.read_n != periph_pkg::SIZE_NONE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= '0;
            irq_q  <= 1'b0;
        end else if (write_en) begin
            if (i_bus.address == periph_pkg::SCR_OFF_DATA) begin
                // Narrow writes replace only the low bits
                case (i_bus.write_n)
                    periph_pkg::SIZE_BYTE: data_q[7:0]  <= i_bus.wdata[7:0];
                    periph_pkg::SIZE_HALF: data_q[15:0] <= i_bus.wdata[15:0];
                    default:               data_q       <= i_bus.wdata;
                endcase
                irq_q <= 1'b1;
            end else if (i_bus.address == periph_pkg::SCR_OFF_IRQ) begin
                irq_q <= 1'b0;
            end
        end
    end

    // Read data follows one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= read_en;
        end
    end

    always_ff @(posedge clk) begin
        if (read_en) begin
            if (i_bus.address == periph_pkg::SCR_OFF_DATA) begin
                rdata_q <= data_q;
            end else if (i_bus.address == periph_pkg::SCR_OFF_IRQ) begin
                rdata_q <= {31'h0, irq_q};
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign i_bus.rdata = rdata_q;
    assign i_bus.ready = ready_q;
    assign o_pins      = data_q[7:0];
    assign o_irq       = irq_q;

endmodule

`default_nettype wire

//--- hw/byte_regs_peri.sv
/*
 * Small register file on a byte-interface slot
 * Register 0 drives the slot's pin byte
 */
`timescale 1ns/1ps
`default_nettype none

module byte_regs_peri #(
    parameter int NUM_BYTE_REGS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    byte_bus_if.periph        i_bus,
    output periph_pkg::pins_t o_pins
);

    periph_pkg::byte_t regs_q [NUM_BYTE_REGS];
    periph_pkg::byte_t rdata;

    for (genvar r = 0; r < NUM_BYTE_REGS; r++) begin : g_reg
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                regs_q[r] <= '0;
            end else if (i_bus.write && i_bus.address == periph_pkg::simple_off_t'(r)) begin
                regs_q[r] <= i_bus.wdata;
            end
        end
    end

    // Offsets past the last register read zero
    always_comb begin
        rdata = '0;
        for (int r = 0; r < NUM_BYTE_REGS; r++) begin
            if (i_bus.address == periph_pkg::simple_off_t'(r)) begin
                rdata = regs_q[r];
            end
        end
    end

    assign i_bus.rdata = rdata;
    assign o_pins      = regs_q[0];

endmodule

`default_nettype wire

//--- hw/periph_top.sv
/*
 * Peripheral wrapper top level
 * Core bus in, slot decode, read return, GPIO and the populated slots
 */
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
    parameter int NUM_BYTE_REGS = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  periph_pkg::bus_addr_t    i_addr,
    input  periph_pkg::word_t        i_data,
    input  periph_pkg::access_size_t i_write_n,
    input  periph_pkg::access_size_t i_read_n,
    input  logic                     i_data_read_complete,
    input  periph_pkg::pins_t        i_ui_in,
    output periph_pkg::word_t        o_data,
    output logic                     o_data_ready,
    output periph_pkg::pins_t        o_uo_out,
    output logic [1:0]               o_user_irq
);

    periph_bus_if user_bus [periph_pkg::NUM_SLOTS] ();
    byte_bus_if   simple_bus [periph_pkg::NUM_SLOTS] ();

    periph_pkg::pins_t user_pins [periph_pkg::NUM_SLOTS];
    periph_pkg::pins_t simple_pins [periph_pkg::NUM_SLOTS];
    periph_pkg::word_t slot_rdata;
    logic              slot_rready;
    logic              read_block;

    periph_addr_decode i_decode (
        .i_addr       (i_addr),
        .i_data       (i_data),
        .i_write_n    (i_write_n),
        .i_read_n     (i_read_n),
        .i_read_block (read_block),
        .o_user       (user_bus),
        .o_simple     (simple_bus),
        .o_rdata      (slot_rdata),
        .o_rready     (slot_rready)
    );

    periph_read_return i_read_return (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_read_n             (i_read_n),
        .i_write_n            (i_write_n),
        .i_rdata              (slot_rdata),
        .i_rready             (slot_rready),
        .i_data_read_complete (i_data_read_complete),
        .o_read_block         (read_block),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready)
    );

    gpio_ctrl i_gpio (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_bus         (user_bus[periph_pkg::SLOT_GPIO]),
        .i_ui_in       (i_ui_in),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_uo_out      (o_uo_out)
    );

    scratch_peri i_scratch0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_bus  (user_bus[periph_pkg::SLOT_SCRATCH0]),
        .o_pins (user_pins[periph_pkg::SLOT_SCRATCH0]),
        .o_irq  (o_user_irq[0])
    );

    scratch_peri i_scratch1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_bus  (user_bus[periph_pkg::SLOT_SCRATCH1]),
        .o_pins (user_pins[periph_pkg::SLOT_SCRATCH1]),
        .o_irq  (o_user_irq[1])
    );

    byte_regs_peri #(.NUM_BYTE_REGS(NUM_BYTE_REGS)) i_byte_regs0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_bus  (simple_bus[periph_pkg::SIMPLE_BYTE0]),
        .o_pins (simple_pins[periph_pkg::SIMPLE_BYTE0])
    );

    byte_regs_peri #(.NUM_BYTE_REGS(NUM_BYTE_REGS)) i_byte_regs1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_bus  (simple_bus[periph_pkg::SIMPLE_BYTE1]),
        .o_pins (simple_pins[periph_pkg::SIMPLE_BYTE1])
    );

    // Empty slots read zero and never stall the core
    for (genvar g = 0; g < periph_pkg::NUM_SLOTS; g++) begin : g_tie
        if (g != int'(periph_pkg::SLOT_SCRATCH0) && g != int'(periph_pkg::SLOT_SCRATCH1)) begin
            // GPIO substitutes its own output byte for this entry
            assign user_pins[g] = '0;
            if (g != int'(periph_pkg::SLOT_GPIO)) begin : g_empty_user
                assign user_bus[g].rdata = '0;
                assign user_bus[g].ready = 1'b1;
            end
        end
        if (g != int'(periph_pkg::SIMPLE_BYTE0) && g != int'(periph_pkg::SIMPLE_BYTE1)) begin
            assign simple_bus[g].rdata = '0;
            assign simple_pins[g]      = '0;
        end
    end

endmodule

`default_nettype wire

//--- include/tb_periph_tasks.svh
/*
 * Testbench tasks for the peripheral wrapper
 * Core bus accesses, typed compares and the directed tests
 */
`ifndef TB_PERIPH_TASKS_SVH
`define TB_PERIPH_TASKS_SVH

// Galois LFSR, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] value;
    logic        out_bit;
    value = '0;
    for (int n = 0; n < count; n++) begin
        out_bit    = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (out_bit ? 32'h8020_0003 : 32'h0);
        value      = {value[30:0], out_bit};
    end
    return value;
endfunction

// Bit 10 clear selects the 64-byte slots
function automatic periph_pkg::bus_addr_t user_addr(input periph_pkg::slot_t slot,
                                                    input periph_pkg::user_off_t off);
    return {1'b0, slot, off};
endfunction

function automatic periph_pkg::bus_addr_t simple_addr(input periph_pkg::slot_t slot,
                                                      input periph_pkg::simple_off_t off);
    return {1'b1, 2'b00, slot, off};
endfunction

// One select word per pin above the select base
function automatic periph_pkg::user_off_t sel_offset(input int pin);
    return periph_pkg::user_off_t'(int'(periph_pkg::GPIO_OFF_SEL) + 4 * pin);
endfunction

task automatic check_word(input string name, input periph_pkg::word_t expected,
                          input periph_pkg::word_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERR %s expected %h actual %h", name, expected, actual);
    end
endtask

task automatic check_pins(input string name, input periph_pkg::pins_t expected,
                          input periph_pkg::pins_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERR %s expected %h actual %h", name, expected, actual);
    end
endtask

task automatic check_irq(input string name, input logic [1:0] expected,
                         input logic [1:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERR %s expected %b actual %b", name, expected, actual);
    end
endtask

// Writes are acknowledged in the cycle they are presented
task automatic bus_write(input periph_pkg::bus_addr_t addr, input periph_pkg::word_t data,
                         input periph_pkg::access_size_t size);
    @(negedge clk);
    i_addr    = addr;
    i_data    = data;
    i_write_n = size;
    #1;
    if (o_data_ready !== 1'b1) begin
        error_count++;
        $display("Write to address %h was not acknowledged by o_data_ready", addr);
    end
    @(negedge clk);
    i_write_n = periph_pkg::SIZE_NONE;
endtask

task automatic wait_data_ready(input string name);
    int cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (o_data_ready !== 1'b1 && cycles < READY_TIMEOUT);
    if (o_data_ready !== 1'b1) begin
        error_count++;
        $display("%s: o_data_ready did not rise within %0d cycles", name, READY_TIMEOUT);
    end
endtask

task automatic pulse_complete();
    @(negedge clk);
    i_data_read_complete = 1'b1;
    @(negedge clk);
    i_data_read_complete = 1'b0;
endtask

// Read without reporting completion, the returned word stays held
task automatic read_request(input string name, input periph_pkg::bus_addr_t addr,
                            output periph_pkg::word_t data);
    @(negedge clk);
    i_addr   = addr;
    i_read_n = periph_pkg::SIZE_WORD;
    wait_data_ready(name);
    i_read_n = periph_pkg::SIZE_NONE;
    data     = o_data;
endtask

task automatic bus_read(input string name, input periph_pkg::bus_addr_t addr,
                        output periph_pkg::word_t data);
    read_request(name, addr, data);
    pulse_complete();
endtask

task automatic reset_values();
    periph_pkg::word_t data;
    check_pins("reset uo_out", '0, o_uo_out);
    check_irq("reset irq", 2'b00, o_user_irq);
    check_count++;
    if (o_data_ready !== 1'b0) begin
        error_count++;
        $display("o_data_ready is high after reset with no request");
    end
    for (int p = 0; p < 8; p++) begin
        bus_read("reset sel", user_addr(periph_pkg::SLOT_GPIO, sel_offset(p)), data);
        check_word($sformatf("reset sel%0d", p), {27'h0, 1'b0, periph_pkg::SLOT_GPIO}, data);
    end
endtask

task automatic gpio_access();
    periph_pkg::pins_t out_val;
    periph_pkg::pins_t in_val;
    periph_pkg::word_t data;
    out_val = periph_pkg::pins_t'(lfsr_bits(8));
    in_val  = periph_pkg::pins_t'(lfsr_bits(8));
    bus_write(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OFF_OUT), {24'h0, out_val},
              periph_pkg::SIZE_BYTE);
    bus_read("gpio out", user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OFF_OUT), data);
    check_word("gpio out", {24'h0, out_val}, data);
    check_pins("gpio out pins", out_val, o_uo_out);
    @(negedge clk);
    i_ui_in = in_val;
    bus_read("gpio in", user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OFF_IN), data);
    check_word("gpio in", {24'h0, in_val}, data);
endtask

task automatic scratch_slot(input periph_pkg::slot_t slot, input logic [1:0] irq_set);
    string             name;
    periph_pkg::word_t word_val;
    periph_pkg::word_t half_val;
    periph_pkg::word_t byte_val;
    periph_pkg::word_t expected;
    periph_pkg::word_t data;
    name     = $sformatf("scratch%0d", slot);
    word_val = lfsr_bits(32);
    half_val = lfsr_bits(32);
    byte_val = lfsr_bits(32);
    bus_write(user_addr(slot, periph_pkg::SCR_OFF_DATA), word_val, periph_pkg::SIZE_WORD);
    bus_write(user_addr(slot, periph_pkg::SCR_OFF_DATA), half_val, periph_pkg::SIZE_HALF);
    bus_write(user_addr(slot, periph_pkg::SCR_OFF_DATA), byte_val, periph_pkg::SIZE_BYTE);
    // Narrow writes only replace the low bits
    expected       = word_val;
    expected[15:0] = half_val[15:0];
    expected[7:0]  = byte_val[7:0];
    bus_read(name, user_addr(slot, periph_pkg::SCR_OFF_DATA), data);
    check_word({name, " data"}, expected, data);
    check_irq({name, " irq set"}, irq_set, o_user_irq);
    bus_read(name, user_addr(slot, periph_pkg::SCR_OFF_IRQ), data);
    check_word({name, " irq read"}, 32'h1, data);
    bus_write(user_addr(slot, periph_pkg::SCR_OFF_IRQ), '0, periph_pkg::SIZE_WORD);
    check_irq({name, " irq clear"}, 2'b00, o_user_irq);
    bus_read(name, user_addr(slot, periph_pkg::SCR_OFF_IRQ), data);
    check_word({name, " irq read after clear"}, 32'h0, data);
endtask

task automatic byte_slots();
    periph_pkg::word_t values [NUM_BYTE_REGS];
    periph_pkg::slot_t slots [2];
    periph_pkg::word_t data;
    slots[0] = periph_pkg::SIMPLE_BYTE0;
    slots[1] = periph_pkg::SIMPLE_BYTE1;
    for (int s = 0; s < 2; s++) begin
        // All registers written first so that aliasing shows up on readback
        for (int r = 0; r < NUM_BYTE_REGS; r++) begin
            values[r] = lfsr_bits(32);
            bus_write(simple_addr(slots[s], periph_pkg::simple_off_t'(r)), values[r],
                      periph_pkg::SIZE_BYTE);
        end
        for (int r = 0; r < NUM_BYTE_REGS; r++) begin
            bus_read("byte reg", simple_addr(slots[s], periph_pkg::simple_off_t'(r)), data);
            check_word($sformatf("byte%0d reg%0d", slots[s], r), {24'h0, values[r][7:0]}, data);
        end
        if (NUM_BYTE_REGS < 16) begin
            bus_read("byte past end",
                     simple_addr(slots[s], periph_pkg::simple_off_t'(NUM_BYTE_REGS)), data);
            check_word($sformatf("byte%0d past end", slots[s]), 32'h0, data);
        end
    end
endtask

task automatic empty_slots();
    periph_pkg::word_t data;
    bus_write(user_addr(4'd9, 6'h00), lfsr_bits(32), periph_pkg::SIZE_WORD);
    bus_read("empty user9", user_addr(4'd9, 6'h00), data);
    check_word("empty user9", 32'h0, data);
    bus_write(simple_addr(4'd7, 4'h0), lfsr_bits(32), periph_pkg::SIZE_BYTE);
    bus_read("empty simple7", simple_addr(4'd7, 4'h0), data);
    check_word("empty simple7", 32'h0, data);
endtask

task automatic pin_routing();
    periph_pkg::word_t scr_val;
    periph_pkg::byte_t reg_val;
    periph_pkg::pins_t gpio_val;
    periph_pkg::pins_t expected;
    periph_pkg::word_t data;
    bus_write(user_addr(periph_pkg::SLOT_GPIO, sel_offset(3)),
              {27'h0, 1'b0, periph_pkg::SLOT_SCRATCH0}, periph_pkg::SIZE_WORD);
    bus_write(user_addr(periph_pkg::SLOT_GPIO, sel_offset(6)),
              {27'h0, 1'b1, periph_pkg::SIMPLE_BYTE1}, periph_pkg::SIZE_WORD);
    bus_read("sel6", user_addr(periph_pkg::SLOT_GPIO, sel_offset(6)), data);
    check_word("sel6 readback", 32'd17, data);
    for (int n = 0; n < 2; n++) begin
        scr_val  = lfsr_bits(32);
        reg_val  = periph_pkg::byte_t'(lfsr_bits(8));
        gpio_val = periph_pkg::pins_t'(lfsr_bits(8));
        bus_write(user_addr(periph_pkg::SLOT_SCRATCH0, periph_pkg::SCR_OFF_DATA), scr_val,
                  periph_pkg::SIZE_WORD);
        bus_write(simple_addr(periph_pkg::SIMPLE_BYTE1, 4'h0), {24'h0, reg_val},
                  periph_pkg::SIZE_BYTE);
        bus_write(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OFF_OUT), {24'h0, gpio_val},
                  periph_pkg::SIZE_BYTE);
        // Pin 3 from scratch slot 4, pin 6 from byte slot 1, rest from GPIO
        expected    = gpio_val;
        expected[3] = scr_val[3];
        expected[6] = reg_val[6];
        check_pins($sformatf("routing round %0d", n), expected, o_uo_out);
    end
    bus_write(user_addr(periph_pkg::SLOT_SCRATCH0, periph_pkg::SCR_OFF_IRQ), '0,
              periph_pkg::SIZE_WORD);
endtask

task automatic read_hold();
    periph_pkg::bus_addr_t addr;
    periph_pkg::byte_t     first_val;
    periph_pkg::byte_t     second_val;
    periph_pkg::word_t     data;
    addr       = simple_addr(periph_pkg::SIMPLE_BYTE0, 4'h0);
    first_val  = periph_pkg::byte_t'(lfsr_bits(8));
    second_val = periph_pkg::byte_t'(lfsr_bits(8));
    if (second_val == first_val) begin
        second_val = ~first_val;
    end
    bus_write(addr, {24'h0, first_val}, periph_pkg::SIZE_BYTE);
    read_request("hold first", addr, data);
    check_word("hold first", {24'h0, first_val}, data);
    bus_write(addr, {24'h0, second_val}, periph_pkg::SIZE_BYTE);

    // Second read issued while the first word is still held
    @(negedge clk);
    i_addr   = addr;
    i_read_n = periph_pkg::SIZE_WORD;
    repeat (4) begin
        @(negedge clk);
        check_word("hold keeps data", {24'h0, first_val}, o_data);
        if (o_data_ready !== 1'b0) begin
            error_count++;
            $display("o_data_ready rose before the held read was completed");
        end
    end
    pulse_complete();
    wait_data_ready("hold second");
    i_read_n = periph_pkg::SIZE_NONE;
    check_word("hold second", {24'h0, second_val}, o_data);
    pulse_complete();
endtask

`endif

//--- verification/tb_periph_top.sv
/*
 * Testbench for the peripheral wrapper
 * Directed tests over GPIO, scratch and byte slots, pin routing and read hold
 */
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top;

    localparam int NUM_BYTE_REGS = 4;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    // Bus accesses issued by the whole test sequence, rounded up
    localparam int NUM_ACCESSES  = 64;
    localparam int ACCESS_CYCLES = 40;
    localparam int READY_TIMEOUT = 20;

    logic                     clk;
    logic                     rst_n;
    periph_pkg::bus_addr_t    i_addr;
    periph_pkg::word_t        i_data;
    periph_pkg::access_size_t i_write_n;
    periph_pkg::access_size_t i_read_n;
    logic                     i_data_read_complete;
    periph_pkg::pins_t        i_ui_in;
    periph_pkg::word_t        o_data;
    logic                     o_data_ready;
    periph_pkg::pins_t        o_uo_out;
    logic [1:0]               o_user_irq;

    int          error_count;
    int          check_count;
    logic [31:0] lfsr_state;

    periph_top #(.NUM_BYTE_REGS(NUM_BYTE_REGS)) i_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_write_n            (i_write_n),
        .i_read_n             (i_read_n),
        .i_data_read_complete (i_data_read_complete),
        .i_ui_in              (i_ui_in),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready),
        .o_uo_out             (o_uo_out),
        .o_user_irq           (o_user_irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "tb_periph_tasks.svh"

    // Watchdog sized for the worst case of every planned access
    initial begin
        repeat (RESET_CYCLES + NUM_ACCESSES * ACCESS_CYCLES) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display("Errors found");
        $finish;
    end

    initial begin
        clk                  = 1'b0;
        rst_n                = 1'b0;
        i_addr               = '0;
        i_data               = '0;
        i_write_n            = periph_pkg::SIZE_NONE;
        i_read_n             = periph_pkg::SIZE_NONE;
        i_data_read_complete = 1'b0;
        i_ui_in              = '0;
        error_count          = 0;
        check_count          = 0;
        lfsr_state           = 32'h5554;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        gpio_access();
        scratch_slot(periph_pkg::SLOT_SCRATCH0, 2'b01);
        scratch_slot(periph_pkg::SLOT_SCRATCH1, 2'b10);
        byte_slots();
        empty_slots();
        pin_routing();
        read_hold();

        repeat (2) @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hw/periph_pkg.sv
hw/periph_bus_if.sv
hw/periph_addr_decode.sv
hw/periph_read_return.sv
hw/gpio_ctrl.sv
hw/scratch_peri.sv
hw/byte_regs_peri.sv
hw/periph_top.sv
verification/tb_periph_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral wrapper testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing -f files.f --top-module tb_periph_top \
    -Mdir "$BUILD_DIR" -o sim_tb

"./$BUILD_DIR/sim_tb" | tee "$LOG_FILE"

if grep -q "Errors found" "$LOG_FILE"; then
    echo "Simulation FAILED, see $LOG_FILE"
    exit 1
fi

echo "Simulation PASSED"
